/* sim.f */
logic/interp_pkg.sv
logic/fir_pkg.sv
logic/phase_sequencer.sv
logic/source_stuffer.sv
logic/fir_delay_line.sv
logic/fir_mac.sv
logic/fm_interpolator.sv
verification/fm_interpolator_assertions.sv
verification/fm_interpolator_tb.sv

/* Bender.yml */
package:
  name: fm_interpolator

sources:
  - logic/interp_pkg.sv
  - logic/fir_pkg.sv
  - logic/phase_sequencer.sv
  - logic/source_stuffer.sv
  - logic/fir_delay_line.sv
  - logic/fir_mac.sv
  - logic/fm_interpolator.sv
  - target: simulation
    files:
      - verification/fm_interpolator_assertions.sv
      - verification/fm_interpolator_tb.sv

/* verification/fm_interpolator_tb.sv */
// Directed testbench for the FM interpolator output stage.
// A cycle model of the stuffing sequence and the FIR predicts every result.
// The run is bounded by a watchdog sized from the output count of each test.

`timescale 1ns/1ps

module fm_interpolator_tb import interp_pkg::*, fir_pkg::*;;

	localparam int CLK_PERIOD = 100;

	// output pulses consumed by each test, used to size the watchdog.
	localparam int RESET_OUTS = 1;
	localparam int IMPULSE_OUTS = 16;
	localparam int OTHER_OUTS = 20;
	localparam int LATCH_OUTS = 8;
	localparam int RANDOM_OUTS = 64;
	localparam int MARGIN_OUTS = 32;
	localparam int TOTAL_OUTS = RESET_OUTS + IMPULSE_OUTS + OTHER_OUTS + LATCH_OUTS
		+ RANDOM_OUTS + MARGIN_OUTS;

	logic clk;
	logic rst;
	logic sample_in;
	logic signed [SAMPLE_W-1:0] left_in;
	logic signed [SAMPLE_W-1:0] right_in;
	logic signed [SAMPLE_W-1:0] left_other;
	logic signed [SAMPLE_W-1:0] right_other;
	logic signed [OUT_W-1:0] left_out;
	logic signed [OUT_W-1:0] right_out;
	logic sample_out;

	int errors;
	int checks;
	int seed;
	logic rand_done;

	// model state, updated in place at each rising edge.
	int m_cnt;
	int m_phase;
	logic m_strobe;
	int lat_fm_l;
	int lat_fm_r;
	int lat_oth_l;
	int lat_oth_r;
	int hist_l [TAPS];
	int hist_r [TAPS];

	// model results, visible from the edge after each push.
	int exp_left;
	int exp_right;
	int push_count;
	int push_phase;

	fm_interpolator dut0 (
		.clk         (clk),
		.rst         (rst),
		.sample_in   (sample_in),
		.left_in     (left_in),
		.right_in    (right_in),
		.left_other  (left_other),
		.right_other (right_other),
		.left_out    (left_out),
		.right_out   (right_out),
		.sample_out  (sample_out)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	// the counter restarts at 1 after CNT_WRAP and the strobe follows one cycle later.
	// a strobe cycle already shows the new phase, which picks the pushed value.
	always @(posedge clk) begin
		int new_l;
		int new_r;
		int sum_l;
		int sum_r;
		if (rst) begin
			m_cnt = 0;
			m_phase = 0;
			m_strobe = 1'b0;
			lat_fm_l = 0;
			lat_fm_r = 0;
			lat_oth_l = 0;
			lat_oth_r = 0;
			for (int i = 0; i < TAPS; i++) begin
				hist_l[i] = 0;
				hist_r[i] = 0;
			end
			exp_left <= 0;
			exp_right <= 0;
			push_count <= 0;
			push_phase <= 0;
		end else begin
			if (m_strobe) begin
				new_l = (m_phase == 0) ? lat_fm_l : ((m_phase == 2) ? lat_oth_l : 0);
				new_r = (m_phase == 0) ? lat_fm_r : ((m_phase == 2) ? lat_oth_r : 0);
				for (int i = TAPS - 1; i > 0; i--) begin
					hist_l[i] = hist_l[i-1];
					hist_r[i] = hist_r[i-1];
				end
				hist_l[0] = new_l;
				hist_r[0] = new_r;
				sum_l = 0;
				sum_r = 0;
				for (int i = 0; i < TAPS; i++) begin
					sum_l += hist_l[i] * COEFS[i];
					sum_r += hist_r[i] * COEFS[i];
				end
				exp_left <= sum_l >>> OUT_SHIFT;
				exp_right <= sum_r >>> OUT_SHIFT;
				push_phase <= m_phase;
				push_count <= push_count + 1;
			end
			if (sample_in) begin
				lat_fm_l = left_in;
				lat_fm_r = right_in;
				lat_oth_l = left_other;
				lat_oth_r = right_other;
			end
			m_strobe = (m_cnt == CNT_WRAP);
			if (m_strobe) begin
				m_cnt = 1;
				m_phase = (m_phase + 1) % 4;
			end else begin
				m_cnt++;
			end
		end
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	task automatic check_value(input logic signed [31:0] actual,
			input logic signed [31:0] expected, input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, actual,
				expected);
		end
	endtask

	// waits for the next result pulse and compares both channels with the model.
	task automatic wait_output(input string what);
		int n;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (sample_out !== 1'b1 && n < 2 * CNT_WRAP);
		if (sample_out !== 1'b1) begin
			errors++;
			$display("Timeout: no sample_out pulse arrived during the %s test", what);
		end else begin
			check_value(left_out, exp_left, {what, " left"});
			check_value(right_out, exp_right, {what, " right"});
		end
	endtask

	// all four inputs are captured together on a one-cycle sample_in pulse.
	task automatic load_sample(input int l, input int r, input int lo, input int ro);
		@(posedge clk);
		sample_in <= 1'b1;
		left_in <= SAMPLE_W'(l);
		right_in <= SAMPLE_W'(r);
		left_other <= SAMPLE_W'(lo);
		right_other <= SAMPLE_W'(ro);
		@(posedge clk);
		sample_in <= 1'b0;
	endtask

	function automatic int random_sample();
		logic signed [SAMPLE_W-1:0] v;
		v = $random(seed);
		return v;
	endfunction

	////////////////////////////////////////
	// directed tests
	////////////////////////////////////////

	// outputs stay at zero until the first pulse, which follows the first strobe.
	task automatic check_reset_state();
		int cycles;
		cycles = 0;
		@(posedge clk);
		while (sample_out !== 1'b1 && cycles < 4 * CNT_WRAP) begin
			check_value(left_out, 0, "left_out before first pulse");
			check_value(right_out, 0, "right_out before first pulse");
			cycles++;
			@(posedge clk);
		end
		check_value(cycles, CNT_WRAP + 1 + MAC_LATENCY, "cycle of first sample_out");
		check_value(left_out, exp_left, "first left result");
		check_value(right_out, exp_right, "first right result");
	endtask

	// the impulse enters on one FM phase and then walks through every tap.
	task automatic fm_impulse_response();
		int base;
		load_sample(100, -100, 0, 0);
		do begin
			base = push_count;
			@(posedge clk);
		end while (push_count == base || push_phase != 0);
		load_sample(0, 0, 0, 0);
		for (int k = 0; k < IMPULSE_OUTS; k++) begin
			wait_output("impulse");
			check_value(left_out, (100 * COEFS[k]) >>> OUT_SHIFT, "impulse left tap");
			check_value(right_out, -((100 * COEFS[k]) >>> OUT_SHIFT),
				"impulse right negation");
		end
	endtask

	task automatic other_source_path();
		load_sample(0, 0, 150, -75);
		repeat (OTHER_OUTS) wait_output("other source");
	endtask

	// a change without sample_in must not reach the filter.
	task automatic sample_latching();
		load_sample(77, -33, 0, 0);
		@(posedge clk);
		left_in <= SAMPLE_W'(-200);
		repeat (LATCH_OUTS) wait_output("latching");
	endtask

	// full scale first, then random loads at random intervals.
	task automatic random_stereo_mix();
		rand_done = 1'b0;
		fork
			begin
				load_sample(-256, -256, -256, -256);
				repeat (4 * CNT_WRAP) @(posedge clk);
				load_sample(255, 255, 255, 255);
				repeat (4 * CNT_WRAP) @(posedge clk);
				while (!rand_done) begin
					load_sample(random_sample(), random_sample(), random_sample(),
						random_sample());
					repeat (($random(seed) & 127) + 1) @(posedge clk);
				end
			end
			begin
				repeat (RANDOM_OUTS) wait_output("random mix");
				rand_done = 1'b1;
			end
		join
	endtask

	////////////////////////////////////////
	// run control
	////////////////////////////////////////

	initial begin
		seed = 32'he54d;
		errors = 0;
		checks = 0;
		rand_done = 1'b0;
		rst = 1'b1;
		sample_in = 1'b0;
		left_in = '0;
		right_in = '0;
		left_other = '0;
		right_other = '0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		check_reset_state();
		fm_impulse_response();
		other_source_path();
		sample_latching();
		random_stereo_mix();
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	// one filter period per expected output, plus margin.
	initial begin
		#(TOTAL_OUTS * CNT_WRAP * CLK_PERIOD);
		$display("Watchdog expired: the tests did not finish in time");
		$display("Errors found");
		$finish;
	end

endmodule

/* verification/fm_interpolator_assertions.sv */
// Strobe timing checks, bound into the interpolator top level.
// All checks are idle while reset is high.

`timescale 1ns/1ps

module fm_interpolator_assertions import interp_pkg::*, fir_pkg::*; (
	input logic clk,
	input logic rst,
	input logic fir_strobe,
	input logic sample_out
);

	////////////////////////////////////////
	// result strobe
	////////////////////////////////////////

	// a result pulse lasts exactly one cycle.
	a_single_pulse: assert property (@(posedge clk) disable iff (rst)
		sample_out |=> !sample_out)
		else $error("sample_out stayed high for more than one cycle");

	// results come exactly one filter period apart.
	a_pulse_period: assert property (@(posedge clk) disable iff (rst)
		sample_out |=> (!sample_out) [*CNT_WRAP-1] ##1 sample_out)
		else $error("sample_out pulses are not one filter period apart");

	////////////////////////////////////////
	// filter latency
	////////////////////////////////////////

	// each filter strobe yields its result after the MAC latency.
	a_strobe_latency: assert property (@(posedge clk) disable iff (rst)
		fir_strobe |-> ##MAC_LATENCY sample_out)
		else $error("sample_out did not follow fir_strobe after the MAC latency");

endmodule

bind fm_interpolator fm_interpolator_assertions u_assertions (
	.clk        (clk),
	.rst        (rst),
	.fir_strobe (fir_strobe),
	.sample_out (sample_out)
);

/* logic/fm_interpolator.sv */
// Output stage of the FM chip: mixes a second same-rate stereo source
// into the FM stream and interpolates it through a zero-stuffed FIR.
// Inputs are captured on sample_in; results come with a one-cycle
// sample_out pulse and hold until the next one. There is no back-pressure.

`timescale 1ns/1ps

module fm_interpolator import interp_pkg::*, fir_pkg::*; (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       sample_in,
	input  logic signed [SAMPLE_W-1:0] left_in,
	input  logic signed [SAMPLE_W-1:0] right_in,
	// the other source must already be filtered down to the FM rate.
	input  logic signed [SAMPLE_W-1:0] left_other,
	input  logic signed [SAMPLE_W-1:0] right_other,
	output logic signed [OUT_W-1:0]    left_out,
	output logic signed [OUT_W-1:0]    right_out,
	output logic                       sample_out
);

	// sequencer outputs.
	logic [PHASE_W-1:0] phase;
	logic               fir_strobe;

	// zero-stuffed stream into the filter.
	logic signed [SAMPLE_W-1:0] stuff_left;
	logic signed [SAMPLE_W-1:0] stuff_right;

	// serial tap read between the MAC and the delay line.
	logic        [TAP_IDX_W-1:0] tap_idx;
	logic signed [SAMPLE_W-1:0]  tap_left;
	logic signed [SAMPLE_W-1:0]  tap_right;

	phase_sequencer u_seq (
		.clk        (clk),
		.rst        (rst),
		.phase      (phase),
		.fir_strobe (fir_strobe)
	);

	source_stuffer u_stuff (
		.clk         (clk),
		.rst         (rst),
		.sample_in   (sample_in),
		.left_in     (left_in),
		.right_in    (right_in),
		.left_other  (left_other),
		.right_other (right_other),
		.phase       (phase),
		.stuff_left  (stuff_left),
		.stuff_right (stuff_right)
	);

	fir_delay_line u_line (
		.clk         (clk),
		.rst         (rst),
		.fir_strobe  (fir_strobe),
		.stuff_left  (stuff_left),
		.stuff_right (stuff_right),
		.tap_idx     (tap_idx),
		.tap_left    (tap_left),
		.tap_right   (tap_right)
	);

	fir_mac u_mac (
		.clk        (clk),
		.rst        (rst),
		.fir_strobe (fir_strobe),
		.tap_left   (tap_left),
		.tap_right  (tap_right),
		.tap_idx    (tap_idx),
		.left_out   (left_out),
		.right_out  (right_out),
		.sample_out (sample_out)
	);

endmodule

/* logic/fir_mac.sv */
// Serial multiply-accumulate over all taps, one tap per cycle per channel.
// Only one computation may be in flight; a strobe during a busy period is
// not expected because strobes are CNT_WRAP cycles apart.
// The coefficient table guarantees that the accumulator never overflows.

`timescale 1ns/1ps

module fir_mac import interp_pkg::*, fir_pkg::*; (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        fir_strobe,
	input  logic signed [SAMPLE_W-1:0]  tap_left,
	input  logic signed [SAMPLE_W-1:0]  tap_right,
	output logic        [TAP_IDX_W-1:0] tap_idx,
	output logic signed [OUT_W-1:0]     left_out,
	output logic signed [OUT_W-1:0]     right_out,
	output logic                        sample_out
);

	////////////////////////////////////////
	// multiply and accumulate
	////////////////////////////////////////

	// high while the tap counter walks the coefficient table.
	logic busy;

	// marks the cycle that handles the oldest tap.
	logic last_tap;

	// coefficient for the tap that is read in this cycle.
	logic signed [COEF_W-1:0] coef;

	// products are formed at full accumulator width.
	// both operands are signed, so they are sign-extended before the multiply.
	logic signed [ACC_W-1:0] prod_left;
	logic signed [ACC_W-1:0] prod_right;

	// running sums and their next values.
	logic signed [ACC_W-1:0] acc_left;
	logic signed [ACC_W-1:0] acc_right;
	logic signed [ACC_W-1:0] acc_next_left;
	logic signed [ACC_W-1:0] acc_next_right;

	// scaled results before truncation to the output width.
	logic signed [ACC_W-1:0] scaled_left;
	logic signed [ACC_W-1:0] scaled_right;

	assign last_tap       = (tap_idx == TAP_IDX_W'(TAPS - 1));
	assign coef           = COEFS[tap_idx];
	assign prod_left      = tap_left * coef;
	assign prod_right     = tap_right * coef;
	assign acc_next_left  = acc_left + prod_left;
	assign acc_next_right = acc_right + prod_right;
	// arithmetic shift keeps the sign of negative sums.
	assign scaled_left    = acc_next_left >>> OUT_SHIFT;
	assign scaled_right   = acc_next_right >>> OUT_SHIFT;

	// the accumulators restart on every strobe.
	// each busy cycle then adds one product per channel.
	always_ff @(posedge clk) begin
		if (fir_strobe) begin
			acc_left  <= '0;
			acc_right <= '0;
		end else if (busy) begin
			acc_left  <= acc_next_left;
			acc_right <= acc_next_right;
		end
	end

	////////////////////////////////////////
	// control and result registers
	////////////////////////////////////////

	// strobe in cycle t starts the walk, taps 0 to 15 are handled in
	// cycles t+1 to t+16, and the result shows in cycle t+17.
	always_ff @(posedge clk) begin
		if (rst) begin
			busy       <= 1'b0;
			tap_idx    <= '0;
			sample_out <= 1'b0;
			left_out   <= '0;
			right_out  <= '0;
		end else begin
			sample_out <= 1'b0;
			if (fir_strobe) begin
				busy    <= 1'b1;
				tap_idx <= '0;
			end else if (busy) begin
				tap_idx <= tap_idx + 1'b1;
				if (last_tap) begin
					busy       <= 1'b0;
					sample_out <= 1'b1;
					left_out   <= scaled_left[OUT_W-1:0];
					right_out  <= scaled_right[OUT_W-1:0];
				end
			end
		end
	end

endmodule

/* logic/fir_delay_line.sv */
// Stereo tap delay line for the serial FIR.
// One shift per fir_strobe; tap 0 always holds the newest stuffed sample.
// The read port is combinational on tap_idx.

`timescale 1ns/1ps

module fir_delay_line import interp_pkg::*, fir_pkg::*; (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       fir_strobe,
	input  logic signed [SAMPLE_W-1:0] stuff_left,
	input  logic signed [SAMPLE_W-1:0] stuff_right,
	input  logic        [TAP_IDX_W-1:0] tap_idx,
	output logic signed [SAMPLE_W-1:0] tap_left,
	output logic signed [SAMPLE_W-1:0] tap_right
);

	////////////////////////////////////////
	// tap storage
	////////////////////////////////////////

	// one shift register per channel.
	// both shift on the same strobe, so the channels never drift apart.
	logic signed [SAMPLE_W-1:0] line_left  [TAPS];
	logic signed [SAMPLE_W-1:0] line_right [TAPS];

	// the strobe cycle already shows the new phase value on the stuffer
	// output, so it is captured at the edge that ends that cycle.
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < TAPS; i++) begin
				line_left[i]  <= '0;
				line_right[i] <= '0;
			end
		end else if (fir_strobe) begin
			line_left[0]  <= stuff_left;
			line_right[0] <= stuff_right;
			for (int i = 1; i < TAPS; i++) begin
				line_left[i]  <= line_left[i-1];
				line_right[i] <= line_right[i-1];
			end
		end
	end

	////////////////////////////////////////
	// read port
	////////////////////////////////////////

	// the MAC walks tap_idx from 0 to TAPS-1 after each strobe.
	// a single read port per channel is enough for the serial multiplier.
	assign tap_left  = line_left[tap_idx];
	assign tap_right = line_right[tap_idx];

endmodule

/* logic/source_stuffer.sv */
// Latches the FM pair and the other-source pair on sample_in and
// interleaves them with zeros by phase. Without a new sample_in the
// last latched values repeat. The output is combinational on phase.

`timescale 1ns/1ps

module source_stuffer import interp_pkg::*; (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       sample_in,
	input  logic signed [SAMPLE_W-1:0] left_in,
	input  logic signed [SAMPLE_W-1:0] right_in,
	input  logic signed [SAMPLE_W-1:0] left_other,
	input  logic signed [SAMPLE_W-1:0] right_other,
	input  logic        [PHASE_W-1:0]  phase,
	output logic signed [SAMPLE_W-1:0] stuff_left,
	output logic signed [SAMPLE_W-1:0] stuff_right
);

	////////////////////////////////////////
	// input latches
	////////////////////////////////////////

	// latched copies of both stereo sources.
	// all four load together so the two sources stay aligned.
	logic signed [SAMPLE_W-1:0] fm_left;
	logic signed [SAMPLE_W-1:0] fm_right;
	logic signed [SAMPLE_W-1:0] oth_left;
	logic signed [SAMPLE_W-1:0] oth_right;

	always_ff @(posedge clk) begin
		if (rst) begin
			fm_left   <= '0;
			fm_right  <= '0;
			oth_left  <= '0;
			oth_right <= '0;
		end else if (sample_in) begin
			fm_left   <= left_in;
			fm_right  <= right_in;
			oth_left  <= left_other;
			oth_right <= right_other;
		end
	end

	////////////////////////////////////////
	// phase select
	////////////////////////////////////////

	// phase 0 presents FM, phase 2 presents the other source.
	// the odd phases insert the zeros of the stuffed stream.
	always_comb begin
		case (phase)
			2'd0: begin
				stuff_left  = fm_left;
				stuff_right = fm_right;
			end
			2'd2: begin
				stuff_left  = oth_left;
				stuff_right = oth_right;
			end
			default: begin
				stuff_left  = '0;
				stuff_right = '0;
			end
		endcase
	end

endmodule

/* logic/phase_sequencer.sv */
// Free-running control for the four-phase zero-stuffing sequence.
// It is not synchronized to sample_in; the first filter strobe comes
// 42 cycles after reset is released and then every CNT_WRAP cycles.

`timescale 1ns/1ps

module phase_sequencer import interp_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	output logic [PHASE_W-1:0] phase,
	output logic               fir_strobe
);

	////////////////////////////////////////
	// period counter
	////////////////////////////////////////

	// counts clock cycles within one filter period.
	// after reset it starts from 0, so the first period is one cycle longer
	// than the following ones, which restart from 1.
	logic [CNT_W-1:0] cnt;

	// high on the cycle where the counter sits at its wrap value.
	// the strobe and the phase step are both taken from this.
	logic wrap;

	assign wrap = (cnt == CNT_W'(CNT_WRAP));

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
		end else if (wrap) begin
			cnt <= CNT_W'(1);
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	////////////////////////////////////////
	// phase and filter strobe
	////////////////////////////////////////

	// the phase advances modulo 4 at every wrap.
	// the order is FM, zero, other, zero.
	// the phase is already updated during the strobe cycle, so the value
	// that enters the delay line belongs to the new phase.
	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= '0;
		end else if (wrap) begin
			phase <= phase + 1'b1;
		end
	end

	// the strobe is registered, so it lines up with the new phase.
	// it stays high for exactly one cycle per period.
	always_ff @(posedge clk) begin
		if (rst) begin
			fir_strobe <= 1'b0;
		end else begin
			fir_strobe <= wrap;
		end
	end

	// downstream blocks only react to phase and fir_strobe.
	// the counter itself never leaves this module.

endmodule

/* logic/fir_pkg.sv */
// Filter constants for the serial interpolation FIR.
// The coefficient table is symmetric and scaled so that a full-scale input
// can never overflow the accumulator, so the MAC does not saturate.

package fir_pkg;

	////////////////////////////////////////
	// filter geometry
	////////////////////////////////////////

	// number of taps in the delay line and in the coefficient table.
	localparam int TAPS = 16;

	// width of a tap index.
	// it addresses TAPS entries.
	localparam int TAP_IDX_W = 4;

	// signed coefficient width.
	localparam int COEF_W = 10;

	////////////////////////////////////////
	// coefficients
	////////////////////////////////////////

	// low-pass response for 4x zero-stuffed interpolation.
	// the sum of absolute values is 1136, so 256 times that is 290816,
	// well inside the 24-bit accumulator.
	// tap 0 multiplies the newest sample.
	localparam logic signed [COEF_W-1:0] COEFS [TAPS] = '{
		-10'sd4,  -10'sd10, -10'sd8,  10'sd12,
		10'sd52,  10'sd110, 10'sd168, 10'sd204,
		10'sd204, 10'sd168, 10'sd110, 10'sd52,
		10'sd12,  -10'sd8,  -10'sd10, -10'sd4
	};

	////////////////////////////////////////
	// accumulation and scaling
	////////////////////////////////////////

	// per-channel accumulator width.
	localparam int ACC_W = 24;

	// arithmetic right shift applied to the accumulator.
	// the low output bits are taken after the shift.
	localparam int OUT_SHIFT = 3;

	// cycles from the filter strobe to the result strobe.
	// one cycle per tap plus the cycle that registers the result.
	localparam int MAC_LATENCY = 17;

endpackage

/* logic/interp_pkg.sv */
// Timing and width constants for the interpolator datapath and its control.
// Samples are two's complement; the period counter assumes a free-running
// sequencer that is never locked to the incoming sample strobe.

package interp_pkg;

	////////////////////////////////////////
	// sample widths
	////////////////////////////////////////

	// width of every input sample from the FM core and from the other source.
	// both sources are signed and share the same rate.
	localparam int SAMPLE_W = 9;

	// width of each interpolated output channel.
	// the MAC scales its accumulator down to this width.
	localparam int OUT_W = 20;

	////////////////////////////////////////
	// sequencer timing
	////////////////////////////////////////

	// the period counter restarts at 1 when it reaches this value.
	// one filter input is therefore consumed every 41 clock cycles.
	localparam int CNT_WRAP = 41;

	// width of the period counter.
	// it must hold CNT_WRAP.
	localparam int CNT_W = 6;

	// width of the phase number.
	// phase 0 carries the FM pair, phase 2 carries the other pair,
	// and phases 1 and 3 insert zeros for the zero-stuffing.
	localparam int PHASE_W = 2;

	// the full stuffing sequence spans four filter periods, so each source
	// reaches the filter once per 164 cycles.
	// the input sample rate is expected to match that interval; a slower
	// source simply repeats its last latched value.

endpackage
